/* bench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
    import lcd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_valid,
    input  logic       i_wr_ready,
    input  logic [1:0] i_wr_addr,
    input  logic [7:0] i_wr_data,
    input  logic       i_lcd_en,
    input  logic       i_lcd_rs,
    input  logic [7:0] i_lcd_data,
    input  logic       i_done,
    output int         o_exp_left,
    output int         o_errors,
    output logic       o_report_done
);

    // Expected LCD transfers as {rs, data}, oldest first
    logic [8:0] exp_q[$];
    logic [8:0] exp;
    int         rises;
    int         accepts;
    int         outstanding;
    int         en_cnt;
    int         gap_cnt;
    int         stable_cnt;
    int         test_err_base;
    int         run_cycles;
    logic       prev_en;
    logic       prev_rs;
    logic [7:0] prev_data;
    logic       last_clear;
    logic       early_ready_seen;

    // The LCD transfer that one host write should turn into
    function automatic logic [8:0] expected_for_write(input logic [1:0] addr,
                                                      input logic [7:0] data);
        logic [8:0] word;
        case (addr)
            REG_DISP:  word = {1'b0, INS_DISPCTL_BASE | (data & 8'h07)};
            REG_ENTRY: word = {1'b0, INS_ENTRY_BASE | (data & 8'h03)};
            REG_ADDR:  word = {1'b0, INS_SET_DDRAM | (data & 8'h7f)};
            default:   word = {1'b1, data};
        endcase
        return word;
    endfunction

    initial begin
        exp_q.push_back({1'b0, INS_FUNCTION_SET});
        exp_q.push_back({1'b0, INS_DISPLAY_OFF});
        exp_q.push_back({1'b0, INS_CLEAR});
        exp_q.push_back({1'b0, INS_ENTRY_BASE | {6'b0, ENTRY_RESET}});
        exp_q.push_back({1'b0, INS_DISPCTL_BASE | {5'b0, DISP_RESET}});
        o_errors         = 0;
        o_exp_left       = exp_q.size();
        o_report_done    = 1'b0;
        rises            = 0;
        accepts          = 0;
        last_clear       = 1'b0;
        early_ready_seen = 1'b0;
    end

    always @(posedge i_clk) begin
        if (i_rst_n) begin
            run_cycles = 0;
            prev_en    = 1'b0;
            prev_rs    = 1'b0;
            prev_data  = 8'h00;
            stable_cnt = 0;
            gap_cnt    = 0;
            en_cnt     = 0;
        end else begin
            run_cycles++;
            if (i_lcd_rs != prev_rs || i_lcd_data != prev_data) begin
                stable_cnt = 0;
            end else begin
                stable_cnt++;
            end
            if (i_wr_ready && rises < INIT_STEPS - 1 && !early_ready_seen) begin
                $display("o_wr_ready went high before the init sequence finished");
                early_ready_seen = 1'b1;
                o_errors++;
            end
            if (i_wr_valid && i_wr_ready) begin
                outstanding = accepts - ((rises > INIT_STEPS) ? rises - INIT_STEPS : 0);
                if (outstanding > 1) begin
                    $display("Write %0d was accepted while a command was still pending", accepts);
                    o_errors++;
                end
                exp_q.push_back(expected_for_write(i_wr_addr, i_wr_data));
                accepts++;
            end
            if (i_lcd_en && !prev_en) begin
                test_err_base = o_errors;
                if (rises == 0 && run_cycles < LCD_POWER_WAIT) begin
                    $display("First E pulse came %0d cycles after reset, too early", run_cycles);
                    o_errors++;
                end
                if (rises > 0 && gap_cnt < (last_clear ? LCD_EXEC_CLEAR : LCD_EXEC_SHORT)) begin
                    $display("E rose only %0d cycles after the previous fall", gap_cnt);
                    o_errors++;
                end
                if (stable_cnt < LCD_SETUP_CYCLES) begin
                    $display("RS and data were stable only %0d cycles before E rose", stable_cnt);
                    o_errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("E pulse %0d appeared with no instruction expected", rises + 1);
                    o_errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (i_lcd_rs != exp[8]) begin
                        $display("ERR o_lcd_rs expected 0x%h got 0x%h", exp[8], i_lcd_rs);
                        o_errors++;
                    end
                    if (i_lcd_data != exp[7:0]) begin
                        $display("ERR o_lcd_data expected 0x%02h got 0x%02h", exp[7:0], i_lcd_data);
                        o_errors++;
                    end
                end
                rises++;
                en_cnt = 1;
            end else if (i_lcd_en) begin
                en_cnt++;
                if (i_lcd_rs != prev_rs) begin
                    $display("ERR o_lcd_rs changed while E high from 0x%h to 0x%h",
                             prev_rs, i_lcd_rs);
                    o_errors++;
                end
                if (i_lcd_data != prev_data) begin
                    $display("ERR o_lcd_data changed while E high from 0x%02h to 0x%02h",
                             prev_data, i_lcd_data);
                    o_errors++;
                end
            end else if (prev_en) begin
                if (en_cnt != LCD_EN_CYCLES) begin
                    $display("ERR o_lcd_en high for 0x%0h cycles, expected 0x%0h",
                             en_cnt, LCD_EN_CYCLES);
                    o_errors++;
                end
                gap_cnt    = 1;
                last_clear = !prev_rs && (prev_data == INS_CLEAR);
                $display("Test %0d rs=%h data=%02h: %s", rises, prev_rs, prev_data,
                         (o_errors == test_err_base) ? "ok" : "FAILED");
            end else begin
                gap_cnt++;
            end
            prev_en    = i_lcd_en;
            prev_rs    = i_lcd_rs;
            prev_data  = i_lcd_data;
            o_exp_left = exp_q.size();
            if (i_done && !o_report_done) begin
                if (exp_q.size() != 0) begin
                    $display("%0d expected instructions never appeared on the LCD bus",
                             exp_q.size());
                    o_errors++;
                end
                $display("Summary: %0d tests, %0d errors", rises, o_errors);
                o_report_done = 1'b1;
            end
        end
    end

endmodule

/* bench/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam real HALF_PERIOD = 10.0;
    localparam int  RST_CYCLES  = 10;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Reset is active high and is released just after a rising edge
    initial begin
        o_rst_n = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b0;
    end

endmodule

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import lcd_pkg::*;
();

    localparam int     NUM_WRITES     = 24;
    localparam int     MAX_IDLE       = 5;
    localparam int     DRAIN_CYCLES   = 3 * LCD_EXEC_SHORT;
    localparam longint TIMEOUT_CYCLES = LCD_POWER_WAIT + 6 * LCD_EXEC_CLEAR
                                        + NUM_WRITES * (LCD_EXEC_SHORT + 100);

    logic       clk;
    logic       rst_n;
    logic       wr_valid;
    logic       wr_ready;
    logic [1:0] wr_addr;
    logic [7:0] wr_data;
    logic       lcd_en;
    logic       lcd_rs;
    logic [7:0] lcd_data;
    logic       done;
    int         exp_left;
    int         errors;
    logic       report_done;
    longint     cycles;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    lcd_top UUT (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_wr_valid (wr_valid),
        .o_wr_ready (wr_ready),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .o_lcd_en   (lcd_en),
        .o_lcd_rs   (lcd_rs),
        .o_lcd_data (lcd_data)
    );

    tb_checker u_checker (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_wr_valid    (wr_valid),
        .i_wr_ready    (wr_ready),
        .i_wr_addr     (wr_addr),
        .i_wr_data     (wr_data),
        .i_lcd_en      (lcd_en),
        .i_lcd_rs      (lcd_rs),
        .i_lcd_data    (lcd_data),
        .i_done        (done),
        .o_exp_left    (exp_left),
        .o_errors      (errors),
        .o_report_done (report_done)
    );

    // Called 1 ns after a rising edge; ready only moves on clock edges
    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        logic taken;
        taken    = 1'b0;
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        while (!taken) begin
            taken = wr_ready;
            @(posedge clk);
            #1;
        end
        wr_valid = 1'b0;
    endtask

    initial begin
        int seed;
        int idle;
        int n;
        wr_valid = 1'b0;
        wr_addr  = 2'd0;
        wr_data  = 8'h00;
        done     = 1'b0;
        seed     = 59;
        void'($urandom(seed));
        @(negedge rst_n);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_WRITES; i++) begin
            idle = $urandom_range(MAX_IDLE, 0);
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
            write_reg(2'($urandom_range(3, 0)), 8'($urandom_range(255, 0)));
        end
        n = 0;
        while (exp_left != 0 && n < DRAIN_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        // Leave room for the last pulse to finish and for any stray pulse to show
        repeat (LCD_EN_CYCLES + 2 * LCD_EXEC_SHORT) @(posedge clk);
        #1 done = 1'b1;
        wait (report_done);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial cycles = 0;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

/* design/lcd_cfg_regs.sv */
`timescale 1ns/1ps

module lcd_cfg_regs
    import lcd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    input  logic       i_wr_valid,
    output logic       o_wr_ready,
    input  logic [1:0] i_wr_addr,
    input  logic [7:0] i_wr_data,

    input  logic       i_init_done,
    input  logic       i_cmd_take,

    output logic       o_cmd_pending,
    output logic [1:0] o_cmd_reg,
    output logic [2:0] o_disp,
    output logic [1:0] o_entry,
    output logic [6:0] o_addr,
    output logic [7:0] o_char
);

    logic       pending;
    logic [1:0] cmd_reg;
    logic [2:0] disp_q;
    logic [1:0] entry_q;
    logic [6:0] addr_q;
    logic [7:0] char_q;
    logic       wr_fire;

    // A single pending command blocks further writes until the sequencer takes it
    assign o_wr_ready = i_init_done && !pending;
    assign wr_fire    = i_wr_valid && o_wr_ready;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            pending <= 1'b0;
            cmd_reg <= REG_DISP;
            disp_q  <= DISP_RESET;
            entry_q <= ENTRY_RESET;
        end else begin
            if (i_cmd_take) begin
                pending <= 1'b0;
            end
            if (wr_fire) begin
                pending <= 1'b1;
                cmd_reg <= i_wr_addr;
                if (i_wr_addr == REG_DISP) begin
                    disp_q <= i_wr_data[2:0];
                end
                if (i_wr_addr == REG_ENTRY) begin
                    entry_q <= i_wr_data[1:0];
                end
            end
        end
    end

    // Last DDRAM address and character written by the host
    always_ff @(posedge i_clk) begin
        if (wr_fire && (i_wr_addr == REG_ADDR)) begin
            addr_q <= i_wr_data[6:0];
        end
        if (wr_fire && (i_wr_addr == REG_CHAR)) begin
            char_q <= i_wr_data;
        end
    end

    assign o_cmd_pending = pending;
    assign o_cmd_reg     = cmd_reg;
    assign o_disp        = disp_q;
    assign o_entry       = entry_q;
    assign o_addr        = addr_q;
    assign o_char        = char_q;

endmodule

/* design/lcd_instr_exec.sv */
`timescale 1ns/1ps

module lcd_instr_exec
    import lcd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    lcd_instr_if.dst   i_instr,

    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic [7:0] o_lcd_data
);

    logic [1:0]           state;
    logic [LCD_CNT_W-1:0] cnt;
    logic                 lcd_en;
    logic                 lcd_rs;
    logic [7:0]           lcd_data;
    logic                 is_clear;

    // Ready only in IDLE, so any valid seen there is a transfer
    assign i_instr.ready = (state == EX_IDLE);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state    <= EX_IDLE;
            cnt      <= '0;
            lcd_en   <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= 8'h00;
            is_clear <= 1'b0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (i_instr.valid) begin
                        lcd_rs   <= i_instr.rs;
                        lcd_data <= i_instr.data;
                        is_clear <= !i_instr.rs && (i_instr.data == INS_CLEAR);
                        cnt      <= LCD_CNT_W'(LCD_SETUP_CYCLES - 1);
                        state    <= EX_SETUP;
                    end
                end
                EX_SETUP: begin
                    // RS and data settle on the bus before E rises
                    if (cnt == '0) begin
                        lcd_en <= 1'b1;
                        cnt    <= LCD_CNT_W'(LCD_EN_CYCLES - 1);
                        state  <= EX_PULSE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                EX_PULSE: begin
                    if (cnt == '0) begin
                        lcd_en <= 1'b0;
                        state  <= EX_WAIT;
                        if (is_clear) begin
                            cnt <= LCD_CNT_W'(LCD_EXEC_CLEAR - 1);
                        end else begin
                            cnt <= LCD_CNT_W'(LCD_EXEC_SHORT - 1);
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    // The controller is busy until the execution time has passed
                    if (cnt == '0) begin
                        state <= EX_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_lcd_en   = lcd_en;
    assign o_lcd_rs   = lcd_rs;
    assign o_lcd_data = lcd_data;

endmodule

/* design/lcd_instr_if.sv */
`timescale 1ns/1ps

// One LCD instruction or data byte on its way to the executor
interface lcd_instr_if;

    logic       valid;
    logic       ready;
    logic       rs;
    logic [7:0] data;

    modport src (
        output valid,
        output rs,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  rs,
        input  data,
        output ready
    );

endinterface

/* design/lcd_pkg.sv */
package lcd_pkg;

    // Bus timing in clock cycles of the 20 ns system clock
    localparam int LCD_SETUP_CYCLES = 2;
    localparam int LCD_EN_CYCLES    = 12;

    // Execution waits after an instruction
    localparam int LCD_EXEC_SHORT   = 2000;
    localparam int LCD_EXEC_CLEAR   = 82000;
    localparam int LCD_POWER_WAIT   = 750000;

    // One counter width covers the longest wait
    localparam int LCD_CNT_W        = $clog2(LCD_POWER_WAIT);

    // Fixed init instructions
    localparam logic [7:0] INS_FUNCTION_SET = 8'h38;
    localparam logic [7:0] INS_DISPLAY_OFF  = 8'h08;
    localparam logic [7:0] INS_CLEAR        = 8'h01;

    // Base opcodes that register fields are merged into
    localparam logic [7:0] INS_ENTRY_BASE   = 8'h04;
    localparam logic [7:0] INS_DISPCTL_BASE = 8'h08;
    localparam logic [7:0] INS_SET_DDRAM    = 8'h80;

    // Host register addresses
    localparam logic [1:0] REG_DISP  = 2'd0;
    localparam logic [1:0] REG_ENTRY = 2'd1;
    localparam logic [1:0] REG_ADDR  = 2'd2;
    localparam logic [1:0] REG_CHAR  = 2'd3;

    // Display on with cursor and blink off, and increment without shift
    localparam logic [2:0] DISP_RESET  = 3'b100;
    localparam logic [1:0] ENTRY_RESET = 2'b10;

    // Function set, display off, clear, entry mode, display control
    localparam int INIT_STEPS = 5;

    // Sequencer states
    localparam logic [1:0] SEQ_POWER = 2'd0;
    localparam logic [1:0] SEQ_INIT  = 2'd1;
    localparam logic [1:0] SEQ_RUN   = 2'd2;

    // Executor states
    localparam logic [1:0] EX_IDLE  = 2'd0;
    localparam logic [1:0] EX_SETUP = 2'd1;
    localparam logic [1:0] EX_PULSE = 2'd2;
    localparam logic [1:0] EX_WAIT  = 2'd3;

endpackage

/* design/lcd_sequencer.sv */
`timescale 1ns/1ps

module lcd_sequencer
    import lcd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    output logic       o_init_done,
    output logic       o_cmd_take,

    input  logic       i_cmd_pending,
    input  logic [1:0] i_cmd_reg,
    input  logic [2:0] i_disp,
    input  logic [1:0] i_entry,
    input  logic [6:0] i_addr,
    input  logic [7:0] i_char,

    lcd_instr_if.src   o_instr
);

    logic [1:0]           state;
    logic [LCD_CNT_W-1:0] cnt;
    logic [2:0]           step;
    logic                 init_done;
    logic                 instr_valid;
    logic                 instr_rs;
    logic [7:0]           instr_data;
    logic                 xfer;
    logic [7:0]           init_byte;

    // Merge a register field into its base opcode
    function automatic logic [7:0] fmt_cmd(
        input logic [1:0] reg_sel,
        input logic [2:0] disp,
        input logic [1:0] entry,
        input logic [6:0] addr,
        input logic [7:0] chr
    );
        logic [7:0] byte_out;
        case (reg_sel)
            REG_DISP:  byte_out = INS_DISPCTL_BASE | {5'b0, disp};
            REG_ENTRY: byte_out = INS_ENTRY_BASE | {6'b0, entry};
            REG_ADDR:  byte_out = INS_SET_DDRAM | {1'b0, addr};
            default:   byte_out = chr;
        endcase
        return byte_out;
    endfunction

    always_comb begin
        case (step)
            3'd0:    init_byte = INS_FUNCTION_SET;
            3'd1:    init_byte = INS_DISPLAY_OFF;
            3'd2:    init_byte = INS_CLEAR;
            3'd3:    init_byte = INS_ENTRY_BASE | {6'b0, i_entry};
            default: init_byte = INS_DISPCTL_BASE | {5'b0, i_disp};
        endcase
    end

    assign xfer = instr_valid && o_instr.ready;

    // The take pulse lands on the transfer edge so the same command is never reissued
    assign o_cmd_take = xfer && (state == SEQ_RUN);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state       <= SEQ_POWER;
            cnt         <= LCD_CNT_W'(LCD_POWER_WAIT - 1);
            step        <= 3'd0;
            init_done   <= 1'b0;
            instr_valid <= 1'b0;
            instr_rs    <= 1'b0;
            instr_data  <= 8'h00;
        end else begin
            case (state)
                SEQ_POWER: begin
                    if (cnt == '0) begin
                        state <= SEQ_INIT;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                SEQ_INIT: begin
                    if (!instr_valid) begin
                        instr_valid <= 1'b1;
                        instr_rs    <= 1'b0;
                        instr_data  <= init_byte;
                    end else if (xfer) begin
                        instr_valid <= 1'b0;
                        if (step == 3'(INIT_STEPS - 1)) begin
                            state     <= SEQ_RUN;
                            init_done <= 1'b1;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end
                SEQ_RUN: begin
                    if (!instr_valid && i_cmd_pending) begin
                        instr_valid <= 1'b1;
                        instr_rs    <= (i_cmd_reg == REG_CHAR);
                        instr_data  <= fmt_cmd(i_cmd_reg, i_disp, i_entry, i_addr, i_char);
                    end else if (xfer) begin
                        instr_valid <= 1'b0;
                    end
                end
                default: begin
                    state <= SEQ_POWER;
                end
            endcase
        end
    end

    assign o_init_done   = init_done;
    assign o_instr.valid = instr_valid;
    assign o_instr.rs    = instr_rs;
    assign o_instr.data  = instr_data;

endmodule

/* design/lcd_top.sv */
`timescale 1ns/1ps

module lcd_top (
    input  logic       i_clk,
    input  logic       i_rst_n,

    input  logic       i_wr_valid,
    output logic       o_wr_ready,
    input  logic [1:0] i_wr_addr,
    input  logic [7:0] i_wr_data,

    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic [7:0] o_lcd_data
);

    logic       init_done;
    logic       cmd_take;
    logic       cmd_pending;
    logic [1:0] cmd_reg;
    logic [2:0] disp;
    logic [1:0] entry;
    logic [6:0] addr;
    logic [7:0] chr;

    lcd_instr_if u_instr_if ();

    lcd_cfg_regs u_cfg_regs (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_valid    (i_wr_valid),
        .o_wr_ready    (o_wr_ready),
        .i_wr_addr     (i_wr_addr),
        .i_wr_data     (i_wr_data),
        .i_init_done   (init_done),
        .i_cmd_take    (cmd_take),
        .o_cmd_pending (cmd_pending),
        .o_cmd_reg     (cmd_reg),
        .o_disp        (disp),
        .o_entry       (entry),
        .o_addr        (addr),
        .o_char        (chr)
    );

    lcd_sequencer u_sequencer (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .o_init_done   (init_done),
        .o_cmd_take    (cmd_take),
        .i_cmd_pending (cmd_pending),
        .i_cmd_reg     (cmd_reg),
        .i_disp        (disp),
        .i_entry       (entry),
        .i_addr        (addr),
        .i_char        (chr),
        .o_instr       (u_instr_if.src)
    );

    lcd_instr_exec u_instr_exec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_instr    (u_instr_if.dst),
        .o_lcd_en   (o_lcd_en),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_data (o_lcd_data)
    );

endmodule

/* sim.f */
design/lcd_pkg.sv
design/lcd_instr_if.sv
design/lcd_cfg_regs.sv
design/lcd_sequencer.sv
design/lcd_instr_exec.sv
design/lcd_top.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_top.sv
